// File: flist.f
rtl/mem_bus_pkg.sv
rtl/axi_mem_bridge.sv
rtl/bridge_csr.sv
rtl/axi_sram.sv
rtl/core_mem_top.sv
tb/tb_core_mem.sv

// File: rtl/axi_mem_bridge.sv
`timescale 1ns/1ps

module axi_mem_bridge (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  logic               fetch_req,
    input  mem_bus_pkg::addr_t fetch_pc,
    output logic               fetch_done,
    output mem_bus_pkg::data_t fetch_inst,
    input  logic               lsu_ren,
    input  logic               lsu_wen,
    input  mem_bus_pkg::addr_t lsu_addr,
    input  mem_bus_pkg::data_t lsu_wdata,
    input  mem_bus_pkg::strb_t lsu_wmask,
    output logic               lsu_done,
    output mem_bus_pkg::data_t lsu_rdata,
    output logic               awvalid,
    input  logic               awready,
    output mem_bus_pkg::addr_t awaddr,
    output logic               wvalid,
    input  logic               wready,
    output mem_bus_pkg::data_t wdata,
    output mem_bus_pkg::strb_t wstrb,
    output logic               wlast,
    input  logic               bvalid,
    output logic               bready,
    input  mem_bus_pkg::resp_t bresp,
    output logic               arvalid,
    input  logic               arready,
    output mem_bus_pkg::addr_t araddr,
    input  logic               rvalid,
    output logic               rready,
    input  mem_bus_pkg::data_t rdata,
    input  mem_bus_pkg::resp_t rresp,
    output logic               fetch_event,
    output logic               load_event,
    output logic               store_event,
    output logic               resp_error
);
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_addr,
        st_fetch_data,
        st_store_addr,
        st_store_data,
        st_store_resp,
        st_load_addr,
        st_load_data
    } state_t;

    state_t state;
    state_t next_state;
    addr_t  addr_q;
    data_t  wdata_q;
    strb_t  wstrb_q;
    logic   last_fetch; // last completed transaction was a fetch
    logic   lsu_req;
    logic   pick_lsu;
    logic   r_hs;
    logic   b_hs;

    assign lsu_req  = lsu_ren || lsu_wen;
    assign pick_lsu = lsu_req && (last_fetch || !fetch_req); // fetch wins unless lsu is owed a turn

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (enable && pick_lsu) begin
                    next_state = lsu_wen ? st_store_addr : st_load_addr;
                end else if (enable && fetch_req) begin
                    next_state = st_fetch_addr;
                end
            end
            st_fetch_addr: if (arready) next_state = st_fetch_data;
            st_fetch_data: if (rvalid) next_state = st_idle;
            st_store_addr: if (awready) next_state = st_store_data;
            st_store_data: if (wready) next_state = st_store_resp;
            st_store_resp: if (bvalid) next_state = st_idle;
            st_load_addr:  if (arready) next_state = st_load_data;
            st_load_data:  if (rvalid) next_state = st_idle;
            default:       next_state = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            last_fetch <= 1'b0;
        end else begin
            state <= next_state;
            if (fetch_done) begin
                last_fetch <= 1'b1;
            end else if (lsu_done) begin
                last_fetch <= 1'b0;
            end
        end
    end

    // request payload, the value of the accepting cycle is kept
    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            addr_q  <= pick_lsu ? lsu_addr : fetch_pc;
            wdata_q <= lsu_wdata;
            wstrb_q <= lsu_wmask;
        end
    end

    assign arvalid = (state == st_fetch_addr) || (state == st_load_addr);
    assign araddr  = addr_q;
    assign rready  = (state == st_fetch_data) || (state == st_load_data);
    assign awvalid = (state == st_store_addr);
    assign awaddr  = addr_q;
    assign wvalid  = (state == st_store_data);
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign wlast   = (state == st_store_data); // single beat
    assign bready  = (state == st_store_resp);

    assign r_hs = rvalid && rready;
    assign b_hs = bvalid && bready;

    assign fetch_done  = r_hs && (state == st_fetch_data);
    assign load_event  = r_hs && (state == st_load_data);
    assign store_event = b_hs;
    assign fetch_event = fetch_done;
    assign lsu_done    = load_event || store_event;
    assign fetch_inst  = fetch_done ? rdata : '0;
    assign lsu_rdata   = load_event ? rdata : '0;
    assign resp_error  = (r_hs && rresp != resp_okay) || (b_hs && bresp != resp_okay);

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid);

    a_one_addr_channel: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && awvalid));

    // a done pulse must answer a request the requester still holds
    a_fetch_done_req: assert property (@(posedge clock) disable iff (reset)
        fetch_done |-> fetch_req);

    a_lsu_done_req: assert property (@(posedge clock) disable iff (reset)
        lsu_done |-> (lsu_ren || lsu_wen));

endmodule

// File: rtl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram #(
    parameter int SRAM_WORDS = 256,
    parameter int RESP_DELAY = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               awvalid,
    output logic               awready,
    input  mem_bus_pkg::addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  mem_bus_pkg::data_t wdata,
    input  mem_bus_pkg::strb_t wstrb,
    input  logic               wlast,
    output logic               bvalid,
    input  logic               bready,
    output mem_bus_pkg::resp_t bresp,
    input  logic               arvalid,
    output logic               arready,
    input  mem_bus_pkg::addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output mem_bus_pkg::data_t rdata,
    output mem_bus_pkg::resp_t rresp
);
    import mem_bus_pkg::*;

    localparam int    idx_w       = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;
    localparam int    cnt_w       = (RESP_DELAY > 1) ? $clog2(RESP_DELAY) : 1;
    localparam addr_t addr_limit  = addr_t'(SRAM_WORDS * 4);
    localparam logic  short_delay = (RESP_DELAY <= 1);
    localparam logic [cnt_w-1:0] cnt_init = cnt_w'(RESP_DELAY > 1 ? RESP_DELAY - 2 : 0);

    typedef enum logic [1:0] {
        st_idle,
        st_wdata,
        st_wait,
        st_resp
    } state_t;

    data_t            mem [SRAM_WORDS];
    state_t           state;
    logic             is_write;
    logic [cnt_w-1:0] cnt;
    addr_t            addr_q;
    data_t            rdata_q;
    resp_t            resp_q;
    logic             aw_hs;
    logic             w_hs;
    logic             ar_hs;
    logic             resp_hs;

    function automatic logic in_range(input addr_t a);
        return a < addr_limit;
    endfunction

    assign awready = (state == st_idle) && awvalid;
    assign arready = (state == st_idle) && arvalid && !awvalid; // writes first
    assign wready  = (state == st_wdata);
    assign bvalid  = (state == st_resp) && is_write;
    assign rvalid  = (state == st_resp) && !is_write;
    assign bresp   = resp_q;
    assign rresp   = resp_q;
    assign rdata   = rdata_q;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign ar_hs   = arvalid && arready;
    assign resp_hs = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_idle;
            is_write <= 1'b0;
            cnt      <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_hs) begin
                        state    <= st_wdata;
                        is_write <= 1'b1;
                    end else if (ar_hs) begin
                        state    <= short_delay ? st_resp : st_wait;
                        is_write <= 1'b0;
                        cnt      <= cnt_init;
                    end
                end
                st_wdata: begin
                    if (w_hs) begin
                        state <= short_delay ? st_resp : st_wait;
                        cnt   <= cnt_init;
                    end
                end
                st_wait: begin
                    if (cnt == '0) state <= st_resp;
                    else cnt <= cnt - 1'b1;
                end
                st_resp: if (resp_hs) state <= st_idle; // held under back-pressure
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (ar_hs) begin
            if (in_range(araddr)) begin
                rdata_q <= mem[araddr[idx_w+1:2]];
                resp_q  <= resp_okay;
            end else begin
                rdata_q <= '0;
                resp_q  <= resp_slverr;
            end
        end
        if (w_hs) begin
            resp_q <= in_range(addr_q) ? resp_okay : resp_slverr;
            if (in_range(addr_q)) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) mem[addr_q[idx_w+1:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    a_single_beat: assert property (@(posedge clock) disable iff (reset)
        wvalid |-> wlast);

endmodule

// File: rtl/bridge_csr.sv
`timescale 1ns/1ps

module bridge_csr (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  mem_bus_pkg::wb_addr_t wb_adr,
    input  mem_bus_pkg::data_t    wb_dat_w,
    output mem_bus_pkg::data_t    wb_dat_r,
    output logic                  wb_ack,
    input  logic                  fetch_event,
    input  logic                  load_event,
    input  logic                  store_event,
    input  logic                  resp_error,
    output logic                  enable
);
    import mem_bus_pkg::*;

    data_t fetch_count;
    data_t load_count;
    data_t store_count;
    logic  err_flag;
    logic  access;
    logic  wr_ctrl;
    logic  wr_status;
    data_t rd_mux;

    // counters stick at all ones
    function automatic data_t sat_inc(input data_t count, input logic ev);
        data_t result;
        result = count;
        if (ev && count != '1) begin
            result = count + 1'b1;
        end
        return result;
    endfunction

    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_ctrl   = access && wb_we && (wb_adr == csr_ctrl);
    assign wr_status = access && wb_we && (wb_adr == csr_status);

    always_comb begin
        case (wb_adr)
            csr_ctrl:        rd_mux = {31'b0, enable};
            csr_fetch_count: rd_mux = fetch_count;
            csr_load_count:  rd_mux = load_count;
            csr_store_count: rd_mux = store_count;
            csr_status:      rd_mux = {31'b0, err_flag};
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            enable      <= 1'b1;
            fetch_count <= '0;
            load_count  <= '0;
            store_count <= '0;
            err_flag    <= 1'b0;
        end else begin
            wb_ack      <= access;
            fetch_count <= sat_inc(fetch_count, fetch_event);
            load_count  <= sat_inc(load_count, load_event);
            store_count <= sat_inc(store_count, store_event);
            if (wr_ctrl) begin
                enable <= wb_dat_w[0];
            end
            // a new error wins over a clear in the same cycle
            err_flag <= resp_error || (err_flag && !(wr_status && wb_dat_w[0]));
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            wb_dat_r <= rd_mux; // snapshot for the ack cycle
        end
    end

    a_ack_single: assert property (@(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

// File: rtl/core_mem_top.sv
`timescale 1ns/1ps

module core_mem_top #(
    parameter int SRAM_WORDS = 256,
    parameter int RESP_DELAY = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fetch_req,
    input  mem_bus_pkg::addr_t    fetch_pc,
    output logic                  fetch_done,
    output mem_bus_pkg::data_t    fetch_inst,
    input  logic                  lsu_ren,
    input  logic                  lsu_wen,
    input  mem_bus_pkg::addr_t    lsu_addr,
    input  mem_bus_pkg::data_t    lsu_wdata,
    input  mem_bus_pkg::strb_t    lsu_wmask,
    output logic                  lsu_done,
    output mem_bus_pkg::data_t    lsu_rdata,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  mem_bus_pkg::wb_addr_t wb_adr,
    input  mem_bus_pkg::data_t    wb_dat_w,
    output mem_bus_pkg::data_t    wb_dat_r,
    output logic                  wb_ack
);
    import mem_bus_pkg::*;

    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  wlast;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;
    logic  enable;
    logic  fetch_event;
    logic  load_event;
    logic  store_event;
    logic  resp_error;

    axi_mem_bridge i_bridge (
        .clock, .reset, .enable,
        .fetch_req, .fetch_pc, .fetch_done, .fetch_inst,
        .lsu_ren, .lsu_wen, .lsu_addr, .lsu_wdata, .lsu_wmask, .lsu_done, .lsu_rdata,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .fetch_event, .load_event, .store_event, .resp_error
    );

    bridge_csr i_csr (
        .clock, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .fetch_event, .load_event, .store_event, .resp_error,
        .enable
    );

    axi_sram #(
        .SRAM_WORDS (SRAM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) i_sram (
        .clock, .reset,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp
    );

endmodule

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] data_t;    // instruction or data word
    typedef logic [3:0]  strb_t;    // byte write mask
    typedef logic [1:0]  resp_t;    // AXI response code
    typedef logic [4:0]  wb_addr_t; // control register byte offset

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // control block register map
    localparam wb_addr_t csr_ctrl        = 5'h00;
    localparam wb_addr_t csr_fetch_count = 5'h04;
    localparam wb_addr_t csr_load_count  = 5'h08;
    localparam wb_addr_t csr_store_count = 5'h0C;
    localparam wb_addr_t csr_status      = 5'h10;

endpackage

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_core_mem -o sim_core_mem

output=$(./obj_dir/sim_core_mem)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
else
    exit 1
fi

// File: tb/tb_core_mem.sv
`timescale 1ns/1ps

module tb_core_mem;
    import mem_bus_pkg::*;

    localparam int sram_words = 256;
    localparam int resp_delay = 2;
    localparam int n_words    = 16;  // low words used by the in-range tests
    localparam int n_partial  = 24;
    localparam int n_mixed    = 24;
    localparam int n_trans    = 2 * n_words + n_words + n_partial + 2 * n_mixed + 40;
    localparam int cycle_limit = n_trans * (resp_delay + 10) + 2000;

    logic     clock;
    logic     reset;
    logic     fetch_req;
    addr_t    fetch_pc;
    logic     fetch_done;
    data_t    fetch_inst;
    logic     lsu_ren;
    logic     lsu_wen;
    addr_t    lsu_addr;
    data_t    lsu_wdata;
    strb_t    lsu_wmask;
    logic     lsu_done;
    data_t    lsu_rdata;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    data_t    wb_dat_w;
    data_t    wb_dat_r;
    logic     wb_ack;

    data_t       ref_mem [sram_words];
    logic [31:0] rng = 32'hf99b;
    string       cur_test = "reset";
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          fetch_seen = 0;
    int          load_seen = 0;
    int          store_seen = 0;
    int          cycles = 0;
    addr_t       fetch_list [n_mixed];
    addr_t       load_list [n_mixed];
    int          fetch_gap [n_mixed];
    int          load_gap [n_mixed];

    core_mem_top #(
        .SRAM_WORDS (sram_words),
        .RESP_DELAY (resp_delay)
    ) i_dut (
        .clock, .reset,
        .fetch_req, .fetch_pc, .fetch_done, .fetch_inst,
        .lsu_ren, .lsu_wen, .lsu_addr, .lsu_wdata, .lsu_wmask, .lsu_done, .lsu_rdata,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic addr_t rand_word_addr();
        logic [31:0] r;
        r = lcg_next();
        return addr_t'((r[15:8] % n_words) * 4);
    endfunction

    // expected read word, zero outside the memory
    function automatic data_t expect_read(input addr_t a);
        if (a >= addr_t'(sram_words * 4)) return '0;
        return ref_mem[a[31:2]];
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t new_word, input strb_t m);
        data_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    // stores outside the memory change nothing
    function automatic void ref_store(input addr_t a, input data_t d, input strb_t m);
        if (a < addr_t'(sram_words * 4)) begin
            ref_mem[a[31:2]] = merge_bytes(ref_mem[a[31:2]], d, m);
        end
    endfunction

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // done pulses are sampled mid-cycle, away from both clock edges
    always @(negedge clock) begin
        if (!reset) begin
            if (fetch_done) begin
                fetch_seen++;
                check_value(cur_test, expect_read(fetch_pc), fetch_inst);
            end
            if (lsu_done && lsu_ren) begin
                load_seen++;
                check_value(cur_test, expect_read(lsu_addr), lsu_rdata);
            end
            if (lsu_done && lsu_wen) begin
                store_seen++;
                ref_store(lsu_addr, lsu_wdata, lsu_wmask);
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // every driver task starts and ends 1 ns after a rising edge
    task automatic do_fetch(input addr_t pc);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        do @(negedge clock); while (!fetch_done);
        @(posedge clock);
        #1 fetch_req = 1'b0;
    endtask

    task automatic do_lsu(input logic wen, input addr_t a, input data_t d, input strb_t m);
        lsu_ren   = !wen;
        lsu_wen   = wen;
        lsu_addr  = a;
        lsu_wdata = d;
        lsu_wmask = m;
        do @(negedge clock); while (!lsu_done);
        @(posedge clock);
        #1;
        lsu_ren = 1'b0;
        lsu_wen = 1'b0;
    endtask

    task automatic wb_access(input logic we, input wb_addr_t a, input data_t d, output data_t q);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = a;
        wb_dat_w = d;
        do @(negedge clock); while (!wb_ack);
        q = wb_dat_r;
        @(posedge clock);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s: %0d errors", cur_test, errors - test_errors);
    endtask

    initial begin
        data_t q;
        strb_t m;
        int    total;
        reset     = 1'b1;
        fetch_req = 1'b0;
        fetch_pc  = '0;
        lsu_ren   = 1'b0;
        lsu_wen   = 1'b0;
        lsu_addr  = '0;
        lsu_wdata = '0;
        lsu_wmask = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (10) @(posedge clock);
        #1 reset = 1'b0;

        begin_test("full_word_rw");
        for (int i = 0; i < n_words; i++) do_lsu(1'b1, addr_t'(i * 4), lcg_next(), 4'hf);
        for (int i = 0; i < n_words; i++) do_lsu(1'b0, addr_t'(i * 4), '0, '0);
        end_test();

        begin_test("partial_mask");
        for (int i = 0; i < n_partial; i++) begin
            m = strb_t'(lcg_next() >> 7);
            if (m == 4'h0 || m == 4'hf) m = 4'b0110; // keep the mask partial
            do_lsu(1'b1, rand_word_addr(), lcg_next(), m);
        end
        for (int i = 0; i < n_words; i++) do_lsu(1'b0, addr_t'(i * 4), '0, '0);
        end_test();

        begin_test("fetch_load_mix");
        for (int i = 0; i < n_mixed; i++) begin
            fetch_list[i] = rand_word_addr();
            load_list[i]  = rand_word_addr();
            fetch_gap[i]  = int'(lcg_next() >> 20) % 3;
            load_gap[i]   = int'(lcg_next() >> 20) % 3;
        end
        total = fetch_seen + load_seen;
        fork
            for (int i = 0; i < n_mixed; i++) begin
                repeat (fetch_gap[i]) begin
                    @(posedge clock);
                    #1;
                end
                do_fetch(fetch_list[i]);
            end
            for (int i = 0; i < n_mixed; i++) begin
                repeat (load_gap[i]) begin
                    @(posedge clock);
                    #1;
                end
                do_lsu(1'b0, load_list[i], '0, '0);
            end
        join
        check_value(cur_test, data_t'(total + 2 * n_mixed), data_t'(fetch_seen + load_seen));
        end_test();

        begin_test("range_error");
        do_lsu(1'b1, addr_t'(sram_words * 4 + 8), lcg_next(), 4'hf);
        wb_access(1'b0, csr_status, '0, q);
        check_value(cur_test, 32'd1, q);
        wb_access(1'b1, csr_status, 32'd1, q);
        wb_access(1'b0, csr_status, '0, q);
        check_value(cur_test, 32'd0, q);
        do_lsu(1'b0, addr_t'(sram_words * 4 + 40), '0, '0); // monitor expects zero data
        wb_access(1'b0, csr_status, '0, q);
        check_value(cur_test, 32'd1, q);
        wb_access(1'b1, csr_status, 32'd1, q);
        do_lsu(1'b0, addr_t'(4), '0, '0);
        wb_access(1'b0, csr_status, '0, q);
        check_value(cur_test, 32'd0, q);
        end_test();

        begin_test("event_counts");
        wb_access(1'b0, csr_fetch_count, '0, q);
        check_value(cur_test, data_t'(fetch_seen), q);
        wb_access(1'b0, csr_load_count, '0, q);
        check_value(cur_test, data_t'(load_seen), q);
        wb_access(1'b0, csr_store_count, '0, q);
        check_value(cur_test, data_t'(store_seen), q);
        end_test();

        begin_test("enable_gate");
        wb_access(1'b1, csr_ctrl, 32'd0, q);
        total = fetch_seen + load_seen + store_seen;
        fork
            do_fetch(rand_word_addr());
            do_lsu(1'b0, rand_word_addr(), '0, '0);
            begin
                repeat (20) @(negedge clock);
                check_value(cur_test, data_t'(total), data_t'(fetch_seen + load_seen + store_seen));
                @(posedge clock);
                #1 wb_access(1'b1, csr_ctrl, 32'd1, q);
            end
        join
        check_value(cur_test, data_t'(total + 2), data_t'(fetch_seen + load_seen + store_seen));
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
